// File: files.f
rtl/cache_pkg.sv
rtl/l1_req_split.sv
rtl/l1_cache.sv
rtl/l2_port_arbiter.sv
rtl/l2_cache.sv
rtl/cache_hier_top.sv
sim/cache_hier_checker.sv
sim/cache_hier_monitor.sv
sim/tb_cache_hier.sv

// File: rtl/cache_hier_top.sv
`timescale 1ns/1ps

module cache_hier_top import cache_pkg::*; #(
   parameter int ADDR_W   = 12,            // Word address
   parameter int DATA_W   = 32,
   parameter int L1_IDX_W = 3,             // 8 lines per L1
   parameter int L2_IDX_W = 5              // 32 lines in L2
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // Processor port
   input  logic                i_valid,
   input  logic                i_instr,
   input  logic [ADDR_W-1:0]   i_addr,
   input  logic [DATA_W-1:0]   i_wdata,
   input  logic [DATA_W/8-1:0] i_wstrb,
   output logic                o_ready,
   output logic [DATA_W-1:0]   o_rdata,
   // Main memory
   output logic                o_mem_valid,
   output logic [ADDR_W-1:0]   o_mem_addr,
   output logic [DATA_W-1:0]   o_mem_wdata,
   output logic [DATA_W/8-1:0] o_mem_wstrb,
   input  logic                i_mem_ready,
   input  logic [DATA_W-1:0]   i_mem_rdata
);

   localparam int STRB_W = DATA_W/8;

   // Splitter to L1 front ends
   logic              l1_valid  [2];
   logic              l1_ready  [2];
   logic [DATA_W-1:0] l1_rdata  [2];
   // L1 memory sides to the merge
   logic              l1m_valid [2];
   logic [ADDR_W-1:0] l1m_addr  [2];
   logic [DATA_W-1:0] l1m_wdata [2];
   logic [STRB_W-1:0] l1m_wstrb [2];
   logic              l1m_ready [2];
   logic [DATA_W-1:0] l1m_rdata;          // Same word to both
   // Merge to L2
   logic              l2_valid;
   logic              l2_ready;
   logic [ADDR_W-1:0] l2_addr;
   logic [DATA_W-1:0] l2_wdata;
   logic [STRB_W-1:0] l2_wstrb;
   logic [DATA_W-1:0] l2_rdata;

   l1_req_split #(
      .DATA_W (DATA_W)
   ) u_l1_req_split (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_valid    (i_valid),
      .i_instr    (i_instr),
      .o_ready    (o_ready),
      .o_rdata    (o_rdata),
      .o_l1_valid (l1_valid),
      .i_l1_ready (l1_ready),
      .i_l1_rdata (l1_rdata)
   );

   ////////////////////
   // L1 caches
   ////////////////////
   for (genvar g = 0; g < 2; g++) begin : g_l1
      l1_cache #(
         .ADDR_W    (ADDR_W),
         .DATA_W    (DATA_W),
         .L1_IDX_W  (L1_IDX_W),
         .READ_ONLY (l1_port_e'(g) == INSTR_PORT)  // Instruction side drops writes
      ) u_l1_cache (
         .clk         (clk),
         .i_rst_n     (i_rst_n),
         .i_valid     (l1_valid[g]),
         .i_addr      (i_addr),
         .i_wdata     (i_wdata),
         .i_wstrb     (i_wstrb),
         .o_ready     (l1_ready[g]),
         .o_rdata     (l1_rdata[g]),
         .o_mem_valid (l1m_valid[g]),
         .o_mem_addr  (l1m_addr[g]),
         .o_mem_wdata (l1m_wdata[g]),
         .o_mem_wstrb (l1m_wstrb[g]),
         .i_mem_ready (l1m_ready[g]),
         .i_mem_rdata (l1m_rdata)
      );
   end

   l2_port_arbiter #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_l2_port_arbiter (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_req_valid (l1m_valid),
      .i_req_addr  (l1m_addr),
      .i_req_wdata (l1m_wdata),
      .i_req_wstrb (l1m_wstrb),
      .o_req_ready (l1m_ready),
      .o_req_rdata (l1m_rdata),
      .o_l2_valid  (l2_valid),
      .o_l2_addr   (l2_addr),
      .o_l2_wdata  (l2_wdata),
      .o_l2_wstrb  (l2_wstrb),
      .i_l2_ready  (l2_ready),
      .i_l2_rdata  (l2_rdata)
   );

   ////////////////////
   // Shared L2
   ////////////////////
   l2_cache #(
      .ADDR_W   (ADDR_W),
      .DATA_W   (DATA_W),
      .L2_IDX_W (L2_IDX_W)
   ) u_l2_cache (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (l2_valid),
      .i_addr      (l2_addr),
      .i_wdata     (l2_wdata),
      .i_wstrb     (l2_wstrb),
      .o_ready     (l2_ready),
      .o_rdata     (l2_rdata),
      .o_mem_valid (o_mem_valid),
      .o_mem_addr  (o_mem_addr),
      .o_mem_wdata (o_mem_wdata),
      .o_mem_wstrb (o_mem_wstrb),
      .i_mem_ready (i_mem_ready),
      .i_mem_rdata (i_mem_rdata)
   );

endmodule

// File: rtl/cache_pkg.sv
package cache_pkg;

   ////////////////////
   // Controller states
   ////////////////////

   // Shared by the L1 and L2 controllers
   typedef enum logic [1:0] {
      IDLE       = 2'd0,  // Waiting for a request
      FILL       = 2'd1,  // Read miss, line comes from below
      WRITE_THRU = 2'd2   // Write sent below, waiting for ack
   } cache_state_e;

   ////////////////////
   // L1 port identities
   ////////////////////

   // Index of each L1 instance in the split, the merge and the top loop
   typedef enum logic {
      INSTR_PORT = 1'b0,  // Instruction cache, read only
      DATA_PORT  = 1'b1   // Data cache
   } l1_port_e;

endpackage

// File: rtl/l1_cache.sv
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; #(
   parameter int ADDR_W    = 12,
   parameter int DATA_W    = 32,
   parameter int L1_IDX_W  = 3,
   parameter bit READ_ONLY = 1'b0          // Set on the instruction side
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // Front end
   input  logic                i_valid,
   input  logic [ADDR_W-1:0]   i_addr,     // Word address
   input  logic [DATA_W-1:0]   i_wdata,
   input  logic [DATA_W/8-1:0] i_wstrb,
   output logic                o_ready,
   output logic [DATA_W-1:0]   o_rdata,
   // Memory side toward the L2 merge
   output logic                o_mem_valid,
   output logic [ADDR_W-1:0]   o_mem_addr,
   output logic [DATA_W-1:0]   o_mem_wdata,
   output logic [DATA_W/8-1:0] o_mem_wstrb,
   input  logic                i_mem_ready,
   input  logic [DATA_W-1:0]   i_mem_rdata
);

   localparam int STRB_W = DATA_W/8;
   localparam int TAG_W  = ADDR_W - L1_IDX_W;
   localparam int LINES  = 2**L1_IDX_W;

   logic [TAG_W-1:0]    tag_mem  [LINES];
   logic [DATA_W-1:0]   data_mem [LINES];
   logic [LINES-1:0]    line_vld;          // One valid bit per line
   cache_state_e        state;

   logic [STRB_W-1:0]   wstrb_eff;
   logic [L1_IDX_W-1:0] idx;
   logic [L1_IDX_W-1:0] fill_idx;          // Taken from the held miss address
   logic [TAG_W-1:0]    tag;
   logic                hit;
   logic                accept;
   logic                is_wr;
   logic [DATA_W-1:0]   merged;            // Hit word with strobed bytes replaced

   assign wstrb_eff = READ_ONLY ? '0 : i_wstrb;
   assign idx       = i_addr[L1_IDX_W-1:0];
   assign tag       = i_addr[ADDR_W-1:L1_IDX_W];
   assign fill_idx  = o_mem_addr[L1_IDX_W-1:0];
   assign hit       = line_vld[idx] && (tag_mem[idx] == tag);
   assign accept    = (state == IDLE) && i_valid && !o_ready;  // Skip the ready cycle
   assign is_wr     = |wstrb_eff;

   always_comb begin
      merged = data_mem[idx];
      for (int b = 0; b < STRB_W; b++) begin
         if (wstrb_eff[b]) begin
            merged[8*b +: 8] = i_wdata[8*b +: 8];
         end
      end
   end

   ////////////////////
   // Controller
   ////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state       <= IDLE;
         o_ready     <= 1'b0;
         o_mem_valid <= 1'b0;
         line_vld    <= '0;
      end else begin
         o_ready <= 1'b0;                  // Single cycle pulse
         case (state)
            IDLE: begin
               if (accept && is_wr) begin
                  state       <= WRITE_THRU;  // Every write goes below
                  o_mem_valid <= 1'b1;
               end else if (accept && hit) begin
                  o_ready     <= 1'b1;        // Read hit
               end else if (accept) begin
                  state       <= FILL;
                  o_mem_valid <= 1'b1;
               end
            end
            FILL: begin
               if (i_mem_ready) begin
                  state              <= IDLE;
                  o_mem_valid        <= 1'b0;
                  o_ready            <= 1'b1;
                  line_vld[fill_idx] <= 1'b1;
               end
            end
            WRITE_THRU: begin
               if (i_mem_ready) begin
                  state       <= IDLE;
                  o_mem_valid <= 1'b0;
                  o_ready     <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Arrays and payload
   ////////////////////
   always_ff @(posedge clk) begin
      if (accept) begin
         o_mem_addr  <= i_addr;            // Held until the ack below
         o_mem_wdata <= i_wdata;
         o_mem_wstrb <= wstrb_eff;         // Zero for a fill
         o_rdata     <= data_mem[idx];
         if (is_wr && hit) begin
            data_mem[idx] <= merged;       // No allocate on a write miss
         end
      end
      if ((state == FILL) && i_mem_ready) begin
         tag_mem[fill_idx]  <= o_mem_addr[ADDR_W-1:L1_IDX_W];
         data_mem[fill_idx] <= i_mem_rdata;
         o_rdata            <= i_mem_rdata;  // Word goes straight up
      end
   end

endmodule

// File: rtl/l1_req_split.sv
`timescale 1ns/1ps

module l1_req_split import cache_pkg::*; #(
   parameter int DATA_W = 32
) (
   input  logic              clk,
   input  logic              i_rst_n,
   // Front end
   input  logic              i_valid,
   input  logic              i_instr,          // Picks the instruction L1
   output logic              o_ready,
   output logic [DATA_W-1:0] o_rdata,
   // Toward the two L1s
   output logic              o_l1_valid [2],
   input  logic              i_l1_ready [2],
   input  logic [DATA_W-1:0] i_l1_rdata [2]
);

   l1_port_e owner_q;                      // L1 that took the open request
   l1_port_e owner;
   logic     open_q;                       // Request accepted, not yet answered

   // First cycle follows i_instr, later cycles follow the stored owner
   assign owner = open_q ? owner_q : (i_instr ? INSTR_PORT : DATA_PORT);

   assign o_l1_valid[INSTR_PORT] = i_valid && (owner == INSTR_PORT);
   assign o_l1_valid[DATA_PORT]  = i_valid && (owner == DATA_PORT);
   assign o_ready = i_l1_ready[owner];     // Response from the owning L1 only
   assign o_rdata = i_l1_rdata[owner];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         open_q  <= 1'b0;
         owner_q <= INSTR_PORT;
      end else if (!open_q && i_valid && !o_ready) begin
         open_q  <= 1'b1;                  // Lock the owner until ready
         owner_q <= owner;
      end else if (o_ready) begin
         open_q  <= 1'b0;
      end
   end

endmodule

// File: rtl/l2_cache.sv
`timescale 1ns/1ps

module l2_cache import cache_pkg::*; #(
   parameter int ADDR_W   = 12,
   parameter int DATA_W   = 32,
   parameter int L2_IDX_W = 5
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // Front end from the L1 merge
   input  logic                i_valid,
   input  logic [ADDR_W-1:0]   i_addr,
   input  logic [DATA_W-1:0]   i_wdata,
   input  logic [DATA_W/8-1:0] i_wstrb,
   output logic                o_ready,
   output logic [DATA_W-1:0]   o_rdata,
   // Native main memory port
   output logic                o_mem_valid,
   output logic [ADDR_W-1:0]   o_mem_addr,
   output logic [DATA_W-1:0]   o_mem_wdata,
   output logic [DATA_W/8-1:0] o_mem_wstrb,
   input  logic                i_mem_ready,
   input  logic [DATA_W-1:0]   i_mem_rdata
);

   localparam int STRB_W = DATA_W/8;
   localparam int TAG_W  = ADDR_W - L2_IDX_W;
   localparam int LINES  = 2**L2_IDX_W;

   logic [TAG_W-1:0]    tag_mem  [LINES];
   logic [DATA_W-1:0]   data_mem [LINES];
   logic [LINES-1:0]    line_vld;
   cache_state_e        state;

   // Lookup on the incoming address
   logic [L2_IDX_W-1:0] lk_idx;
   logic                lk_hit;
   logic                accept;
   // Lookup on the held request, used at fill and write ack
   logic [L2_IDX_W-1:0] rq_idx;
   logic [TAG_W-1:0]    rq_tag;
   logic                rq_hit;
   logic [DATA_W-1:0]   wr_merged;

   assign lk_idx = i_addr[L2_IDX_W-1:0];
   assign lk_hit = line_vld[lk_idx] && (tag_mem[lk_idx] == i_addr[ADDR_W-1:L2_IDX_W]);
   assign accept = (state == IDLE) && i_valid && !o_ready;

   assign rq_idx = o_mem_addr[L2_IDX_W-1:0];
   assign rq_tag = o_mem_addr[ADDR_W-1:L2_IDX_W];
   assign rq_hit = line_vld[rq_idx] && (tag_mem[rq_idx] == rq_tag);

   // Strobed bytes of the held write over the cached word
   always_comb begin
      wr_merged = data_mem[rq_idx];
      for (int b = 0; b < STRB_W; b++) begin
         if (o_mem_wstrb[b]) begin
            wr_merged[8*b +: 8] = o_mem_wdata[8*b +: 8];
         end
      end
   end

   ////////////////////
   // Controller
   ////////////////////
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state       <= IDLE;
         o_ready     <= 1'b0;
         o_mem_valid <= 1'b0;
         line_vld    <= '0;
      end else begin
         o_ready <= 1'b0;
         unique case (state)
            IDLE: begin
               if (accept) begin
                  if (|i_wstrb) begin
                     state       <= WRITE_THRU;
                     o_mem_valid <= 1'b1;
                  end else if (lk_hit) begin
                     o_ready     <= 1'b1;  // Hit, one cycle
                  end else begin
                     state       <= FILL;  // Miss, ask memory
                     o_mem_valid <= 1'b1;
                  end
               end
            end
            FILL, WRITE_THRU: begin
               if (i_mem_ready) begin      // Memory ack ends both
                  state       <= IDLE;
                  o_mem_valid <= 1'b0;
                  o_ready     <= 1'b1;
                  if (state == FILL) begin
                     line_vld[rq_idx] <= 1'b1;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Arrays and payload
   ////////////////////
   always_ff @(posedge clk) begin
      if (accept) begin
         o_mem_addr  <= i_addr;            // Stable under back-pressure
         o_mem_wdata <= i_wdata;
         o_mem_wstrb <= i_wstrb;
         o_rdata     <= data_mem[lk_idx];
      end
      if ((state == FILL) && i_mem_ready) begin
         tag_mem[rq_idx]  <= rq_tag;
         data_mem[rq_idx] <= i_mem_rdata;
         o_rdata          <= i_mem_rdata;
      end
      if ((state == WRITE_THRU) && i_mem_ready && rq_hit) begin
         data_mem[rq_idx] <= wr_merged;    // Update only a resident line
      end
   end

endmodule

// File: rtl/l2_port_arbiter.sv
`timescale 1ns/1ps

module l2_port_arbiter import cache_pkg::*; #(
   parameter int ADDR_W = 12,
   parameter int DATA_W = 32
) (
   input  logic                clk,
   input  logic                i_rst_n,
   // From the two L1 memory sides
   input  logic                i_req_valid [2],
   input  logic [ADDR_W-1:0]   i_req_addr  [2],
   input  logic [DATA_W-1:0]   i_req_wdata [2],
   input  logic [DATA_W/8-1:0] i_req_wstrb [2],
   output logic                o_req_ready [2],
   output logic [DATA_W-1:0]   o_req_rdata,      // Shared by both L1s
   // Toward the L2 front end
   output logic                o_l2_valid,
   output logic [ADDR_W-1:0]   o_l2_addr,
   output logic [DATA_W-1:0]   o_l2_wdata,
   output logic [DATA_W/8-1:0] o_l2_wstrb,
   input  logic                i_l2_ready,
   input  logic [DATA_W-1:0]   i_l2_rdata
);

   l1_port_e grant_q;
   l1_port_e grant;
   logic     held_q;                       // Grant locked on an open request

   // Instruction side wins when both ask from idle
   assign grant = held_q ? grant_q :
                  (i_req_valid[INSTR_PORT] ? INSTR_PORT : DATA_PORT);

   assign o_l2_valid  = i_req_valid[grant];
   assign o_l2_addr   = i_req_addr[grant];
   assign o_l2_wdata  = i_req_wdata[grant];
   assign o_l2_wstrb  = i_req_wstrb[grant];
   assign o_req_rdata = i_l2_rdata;

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         o_req_ready[p] = i_l2_ready && (int'(grant) == p);  // Granted port only
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         held_q  <= 1'b0;
         grant_q <= INSTR_PORT;
      end else if (!held_q && o_l2_valid && !i_l2_ready) begin
         held_q  <= 1'b1;
         grant_q <= grant;
      end else if (i_l2_ready) begin
         held_q  <= 1'b0;                  // Released by the granted ready
      end
   end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the log contents
rm -f sim.log
verilator --binary --timing --assert --top-module tb_cache_hier -f files.f -o sim_cache_hier \
   && ./obj_dir/sim_cache_hier > sim.log 2>&1 \
   || echo "run.sh: build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }

// File: sim/cache_hier_checker.sv
`timescale 1ns/1ps

module cache_hier_checker #(
   parameter int ADDR_W = 12
) (
   input logic              clk,
   input logic              i_rst_n,
   input logic              i_valid,      // Front-end request
   input logic              i_ready,      // Front-end response
   input logic              i_mem_valid,
   input logic [ADDR_W-1:0] i_mem_addr,
   input logic              i_mem_ready
);

   // Failure tallies, summed by the testbench top
   int hold_fails  = 0;
   int ready_fails = 0;
   int reset_fails = 0;

   ////////////////////
   // Memory side
   ////////////////////
   mem_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_mem_valid && !i_mem_ready) |=> (i_mem_valid && $stable(i_mem_addr)))
      else begin
         hold_fails = hold_fails + 1;
         $error("Memory request dropped or moved before its ready");
      end

   // Ready only answers a live request
   ready_in_req: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ready |-> i_valid)
      else begin
         ready_fails = ready_fails + 1;
         $error("Ready pulse while valid was low");
      end

   // First cycle out of reset
   reset_quiet: assert property (@(posedge clk)
      $rose(i_rst_n) |-> (!i_ready && !i_mem_valid))
      else begin
         reset_fails = reset_fails + 1;
         $error("Ready or memory valid high right after reset");
      end

endmodule

// File: sim/cache_hier_monitor.sv
`timescale 1ns/1ps

module cache_hier_monitor #(
   parameter int ADDR_W = 12,
   parameter int DATA_W = 32
) (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_done,      // Stimulus over and totals due
   // Processor port
   input  logic                i_valid,
   input  logic                i_instr,
   input  logic [ADDR_W-1:0]   i_addr,
   input  logic [DATA_W-1:0]   i_wdata,
   input  logic [DATA_W/8-1:0] i_wstrb,
   input  logic                i_ready,
   input  logic [DATA_W-1:0]   i_rdata,
   // Main memory port
   input  logic                i_mem_valid,
   input  logic [ADDR_W-1:0]   i_mem_addr,
   input  logic [DATA_W-1:0]   i_mem_wdata,
   input  logic [DATA_W/8-1:0] i_mem_wstrb,
   input  logic                i_mem_ready,
   output int                  o_rd_errs,
   output int                  o_wr_errs,
   output int                  o_hs_errs
);

   localparam int STRB_W = DATA_W/8;
   localparam int WORDS  = 2**ADDR_W;

   logic [DATA_W-1:0] model [WORDS];       // Memory as the front end sees it
   logic              open_q  = 1'b0;      // Request seen and not yet answered
   logic              wr_seen = 1'b0;      // Memory write seen for it
   logic              closed  = 1'b0;
   logic              is_dwr;
   string             name;
   int                req_cnt = 0;
   int                rsp_cnt = 0;         // Every ready pulse at the front end
   int                dwr_cnt = 0;         // Front-end data writes
   int                mwr_cnt = 0;         // Writes at the memory port
   int                rd_errs = 0;
   int                wr_errs = 0;
   int                hs_errs = 0;

   assign is_dwr    = !i_instr && (|i_wstrb);  // Instruction side never writes
   assign o_rd_errs = rd_errs;
   assign o_wr_errs = wr_errs;
   assign o_hs_errs = hs_errs;

   ////////////////////
   // Compare
   ////////////////////
   always @(posedge clk) begin
      if (!i_rst_n) begin
         for (int a = 0; a < WORDS; a++) begin
            model[a] = DATA_W'(a) ^ DATA_W'(32'h5a5a0000);
         end
         open_q  = 1'b0;
         wr_seen = 1'b0;
      end else begin
         // Write-through traffic
         if (i_mem_valid && i_mem_ready && (|i_mem_wstrb)) begin
            mwr_cnt++;
            if (!open_q || !is_dwr) begin
               $display("Memory write to %h while no data write was open", i_mem_addr);
               wr_errs++;
            end else if (wr_seen) begin
               $display("Second memory write for the data write to %h", i_addr);
               wr_errs++;
            end else if ({i_mem_addr, i_mem_wdata, i_mem_wstrb} != {i_addr, i_wdata, i_wstrb}) begin
               $display("FAIL mem_write expected=%h/%h/%h actual=%h/%h/%h",
                        i_addr, i_wdata, i_wstrb, i_mem_addr, i_mem_wdata, i_mem_wstrb);
               wr_errs++;
            end
            wr_seen = 1'b1;
         end
         // Front-end responses
         if (i_ready) begin
            rsp_cnt++;                       // Counted whether a request is open or not
            if (!open_q) begin
               $display("Ready pulse with no request open");
               hs_errs++;
            end else if (is_dwr) begin
               if (!wr_seen) begin
                  $display("Data write to %h ended without a memory write", i_addr);
                  wr_errs++;
               end
               for (int b = 0; b < STRB_W; b++) begin
                  if (i_wstrb[b]) begin
                     model[i_addr][8*b +: 8] = i_wdata[8*b +: 8];
                  end
               end
            end else begin
               name = i_instr ? "instr_read" : "data_read";
               if (i_rdata !== model[i_addr]) begin
                  $display("FAIL %s addr=%h expected=%h actual=%h",
                           name, i_addr, model[i_addr], i_rdata);
                  rd_errs++;
               end
            end
            open_q  = 1'b0;
            wr_seen = 1'b0;
         end else if (i_valid && !open_q) begin
            open_q = 1'b1;                   // New request starts
            req_cnt++;
            if (is_dwr) begin
               dwr_cnt++;
            end
         end
      end
      // Totals once the stimulus is over
      if (i_done && !closed) begin
         closed = 1'b1;
         if (open_q) begin
            $display("A request was still open at the end of the run");
            hs_errs++;
         end
         if (rsp_cnt != req_cnt) begin
            $display("FAIL ready_count expected=%0d actual=%0d", req_cnt, rsp_cnt);
            hs_errs++;
         end
         if (mwr_cnt != dwr_cnt) begin
            $display("FAIL mem_write_count expected=%0d actual=%0d", dwr_cnt, mwr_cnt);
            wr_errs++;
         end
      end
   end

endmodule

// File: sim/tb_cache_hier.sv
`timescale 1ns/1ps

module tb_cache_hier;

   localparam int ADDR_W     = 12;
   localparam int DATA_W     = 32;
   localparam int STRB_W     = DATA_W/8;
   localparam int WORDS      = 2**ADDR_W;
   localparam int CLK_PERIOD = 8;           // ns
   localparam int N_REQ      = 400;
   localparam int REQ_BOUND  = 40;          // Worst cycles allowed per request
   localparam int SEED       = 32'hc9b6;

   logic                clk = 1'b0;
   logic                i_rst_n;
   logic                i_valid;
   logic                i_instr;
   logic [ADDR_W-1:0]   i_addr;
   logic [DATA_W-1:0]   i_wdata;
   logic [STRB_W-1:0]   i_wstrb;
   logic                o_ready;
   logic [DATA_W-1:0]   o_rdata;
   logic                o_mem_valid;
   logic [ADDR_W-1:0]   o_mem_addr;
   logic [DATA_W-1:0]   o_mem_wdata;
   logic [STRB_W-1:0]   o_mem_wstrb;
   logic                i_mem_ready;
   logic [DATA_W-1:0]   i_mem_rdata;
   logic                done;              // Tells the monitor to close out
   int                  rd_errs;
   int                  wr_errs;
   int                  hs_errs;

   logic [DATA_W-1:0]   mem [WORDS];       // Main memory behind the L2

   always #(CLK_PERIOD/2) clk = ~clk;

   cache_hier_top #(
      .ADDR_W   (ADDR_W),
      .DATA_W   (DATA_W),
      .L1_IDX_W (3),
      .L2_IDX_W (5)
   ) u_cache_hier_top (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (i_valid),
      .i_instr     (i_instr),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_wstrb     (i_wstrb),
      .o_ready     (o_ready),
      .o_rdata     (o_rdata),
      .o_mem_valid (o_mem_valid),
      .o_mem_addr  (o_mem_addr),
      .o_mem_wdata (o_mem_wdata),
      .o_mem_wstrb (o_mem_wstrb),
      .i_mem_ready (i_mem_ready),
      .i_mem_rdata (i_mem_rdata)
   );

   cache_hier_monitor #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_monitor (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_done      (done),
      .i_valid     (i_valid),
      .i_instr     (i_instr),
      .i_addr      (i_addr),
      .i_wdata     (i_wdata),
      .i_wstrb     (i_wstrb),
      .i_ready     (o_ready),
      .i_rdata     (o_rdata),
      .i_mem_valid (o_mem_valid),
      .i_mem_addr  (o_mem_addr),
      .i_mem_wdata (o_mem_wdata),
      .i_mem_wstrb (o_mem_wstrb),
      .i_mem_ready (i_mem_ready),
      .o_rd_errs   (rd_errs),
      .o_wr_errs   (wr_errs),
      .o_hs_errs   (hs_errs)
   );

   // Handshake assertions on the DUT boundary
   bind cache_hier_top cache_hier_checker #(.ADDR_W (ADDR_W)) u_checker (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_valid     (i_valid),
      .i_ready     (o_ready),
      .i_mem_valid (o_mem_valid),
      .i_mem_addr  (o_mem_addr),
      .i_mem_ready (i_mem_ready)
   );

   // Small pool per half, bits 7:6 alias in both caches so lines get evicted
   function automatic logic [ADDR_W-1:0] pick_addr(input logic upper);
      logic [ADDR_W-2:0] low;
      low = (ADDR_W-1)'($urandom_range(3, 0) * 64 + $urandom_range(15, 0));
      return {upper, low};
   endfunction

   // One front-end request, held through the edge that ends the ready pulse
   task automatic run_request(input logic instr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
      i_valid = 1'b1;
      i_instr = instr;
      i_addr  = addr;
      i_wdata = wdata;
      i_wstrb = strb;
      do @(negedge clk); while (!o_ready);
      @(negedge clk);
      i_valid = 1'b0;
      i_wstrb = '0;
   endtask

   ////////////////////
   // Memory responder
   ////////////////////
   initial begin : mem_responder
      int unsigned lat;
      i_mem_ready = 1'b0;
      i_mem_rdata = '0;
      for (int a = 0; a < WORDS; a++) begin
         mem[a] = DATA_W'(a) ^ DATA_W'(32'h5a5a0000);  // Fill from the whole address
      end
      forever begin
         @(negedge clk);
         i_mem_ready = 1'b0;                // Single cycle ack
         if (o_mem_valid) begin
            lat = $urandom_range(3, 0);
            repeat (lat) @(negedge clk);
            i_mem_rdata = mem[o_mem_addr];
            for (int b = 0; b < STRB_W; b++) begin
               if (o_mem_wstrb[b]) begin
                  mem[o_mem_addr][8*b +: 8] = o_mem_wdata[8*b +: 8];
               end
            end
            i_mem_ready = 1'b1;
         end
      end
   end

   ////////////////////
   // Stimulus
   ////////////////////
   initial begin : stimulus
      int unsigned       kind;
      logic              instr;
      logic [ADDR_W-1:0] addr;
      logic [STRB_W-1:0] strb;
      int                asrt_errs;
      int                total;
      i_rst_n = 1'b0;
      i_valid = 1'b0;
      i_instr = 1'b0;
      i_addr  = '0;
      i_wdata = '0;
      i_wstrb = '0;
      done    = 1'b0;
      void'($urandom(SEED));
      repeat (2) @(negedge clk);            // Two cycles in reset
      i_rst_n = 1'b1;
      @(negedge clk);
      for (int n = 0; n < N_REQ; n++) begin
         kind = $urandom_range(9, 0);
         if (kind < 3) begin                // Instruction read, sometimes a stray strobe
            instr = 1'b1;
            addr  = pick_addr(1'b1);
            strb  = ($urandom_range(3, 0) == 0) ? STRB_W'($urandom_range(15, 1)) : '0;
         end else if (kind < 6) begin       // Data read anywhere
            instr = 1'b0;
            addr  = pick_addr(1'($urandom_range(1, 0)));
            strb  = '0;
         end else begin                     // Data write, lower half only
            instr = 1'b0;
            addr  = pick_addr(1'b0);
            strb  = STRB_W'($urandom_range(15, 1));
         end
         run_request(instr, addr, DATA_W'($urandom()), strb);
         repeat ($urandom_range(2, 0)) @(negedge clk);
      end
      done = 1'b1;
      @(negedge clk);                       // Closing checks run on the edge between
      asrt_errs = u_cache_hier_top.u_checker.hold_fails
                + u_cache_hier_top.u_checker.ready_fails
                + u_cache_hier_top.u_checker.reset_fails;
      total = rd_errs + wr_errs + hs_errs + asrt_errs;
      $display("Error counts: read %0d, memory write %0d, handshake %0d, assertion %0d",
               rd_errs, wr_errs, hs_errs, asrt_errs);
      if (total == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // Bound taken from the request count
   initial begin : watchdog
      #(N_REQ * REQ_BOUND * CLK_PERIOD);
      $display("Watchdog expired, the run hung waiting on the DUT");
      $display("Something failed");
      $finish;
   end

endmodule
